/* hw/calib_pkg.sv */
/*
 * Calibration subsystem shared definitions
 * System bus widths and types, register map and default data widths
 */

`default_nettype none

package calib_pkg;

  ////////////////////////////////////////////////////////////
  // System bus
  ////////////////////////////////////////////////////////////

  localparam int unsigned BUS_AW = 32;
  localparam int unsigned BUS_DW = 32;

  typedef logic [BUS_AW-1:0] bus_addr_t;
  typedef logic [BUS_DW-1:0] bus_data_t;

  ////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////

  // Gain width, unity is 1 << (DWM-2)
  localparam int unsigned CALIB_DWM_DEF = 16;
  // Sample and offset width
  localparam int unsigned CALIB_DWS_DEF = 14;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  // Low address bits seen by the block
  localparam int unsigned CALIB_AW = 20;

  // ADC gain and offset pairs
  localparam logic [CALIB_AW-1:0] ADC_MUL0_OFS = 20'h00040;
  localparam logic [CALIB_AW-1:0] ADC_SUM0_OFS = 20'h00044;
  localparam logic [CALIB_AW-1:0] ADC_MUL1_OFS = 20'h00048;
  localparam logic [CALIB_AW-1:0] ADC_SUM1_OFS = 20'h0004C;
  // DAC gain and offset pairs
  localparam logic [CALIB_AW-1:0] DAC_MUL0_OFS = 20'h00050;
  localparam logic [CALIB_AW-1:0] DAC_SUM0_OFS = 20'h00054;
  localparam logic [CALIB_AW-1:0] DAC_MUL1_OFS = 20'h00058;
  localparam logic [CALIB_AW-1:0] DAC_SUM1_OFS = 20'h0005C;

endpackage

`default_nettype wire

/* hw/sys_bus_if.sv */
/*
 * System bus bundle
 * Single-cycle read and write strobes, one-cycle ack and err response
 */

`timescale 1ns/100ps
`default_nettype none

interface sys_bus_if (
  input logic bus,
  input logic arst_n
);
  import calib_pkg::*;

  // Request side
  bus_addr_t addr;
  bus_data_t wdata;
  logic      wen;
  logic      ren;

  // Response side, one cycle after the strobe
  bus_data_t rdata;
  logic      ack;
  logic      err;

  // Bus master
  modport m (
    input  bus, arst_n,
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  // Register slave
  modport s (
    input  bus, arst_n,
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

`default_nettype wire

/* hw/calib_regs.sv */
/*
 * Calibration register block
 * Gain and offset per ADC and DAC channel, written and read over the system bus
 * Unmapped addresses answer with err and zero read data
 */

`timescale 1ns/100ps
`default_nettype none

module calib_regs #(
  parameter int unsigned DWM = calib_pkg::CALIB_DWM_DEF,
  parameter int unsigned DWS = calib_pkg::CALIB_DWS_DEF
) (
  sys_bus_if.s                         sys,
  // ADC channel settings
  output logic signed [1:0][DWM-1:0] adc_mul,
  output logic signed [1:0][DWS-1:0] adc_sum,
  // DAC channel settings
  output logic signed [1:0][DWM-1:0] dac_mul,
  output logic signed [1:0][DWS-1:0] dac_sum
);
  import calib_pkg::*;

  // Gain of one
  localparam logic [DWM-1:0] GAIN_UNITY = DWM'(1) << (DWM-2);

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  logic [CALIB_AW-1:0] reg_addr;
  // One bit per register, in map order
  logic [7:0]          sel;
  logic                hit;
  bus_data_t           rd_mux;

  // Sign extension to bus width
  function automatic bus_data_t sext_mul(input logic signed [DWM-1:0] val);
    return BUS_DW'(val);
  endfunction

  function automatic bus_data_t sext_sum(input logic signed [DWS-1:0] val);
    return BUS_DW'(val);
  endfunction

  assign reg_addr = sys.addr[CALIB_AW-1:0];

  always_comb begin
    sel    = '0;
    rd_mux = '0;
    case (reg_addr)
      ADC_MUL0_OFS: begin sel[0] = 1'b1; rd_mux = sext_mul(adc_mul[0]); end
      ADC_SUM0_OFS: begin sel[1] = 1'b1; rd_mux = sext_sum(adc_sum[0]); end
      ADC_MUL1_OFS: begin sel[2] = 1'b1; rd_mux = sext_mul(adc_mul[1]); end
      ADC_SUM1_OFS: begin sel[3] = 1'b1; rd_mux = sext_sum(adc_sum[1]); end
      DAC_MUL0_OFS: begin sel[4] = 1'b1; rd_mux = sext_mul(dac_mul[0]); end
      DAC_SUM0_OFS: begin sel[5] = 1'b1; rd_mux = sext_sum(dac_sum[0]); end
      DAC_MUL1_OFS: begin sel[6] = 1'b1; rd_mux = sext_mul(dac_mul[1]); end
      DAC_SUM1_OFS: begin sel[7] = 1'b1; rd_mux = sext_sum(dac_sum[1]); end
      // Unmapped, leaves zero data
      default: ;
    endcase
  end

  assign hit = |sel;

  ////////////////////////////////////////////////////////////
  // Setting registers
  ////////////////////////////////////////////////////////////

  // Written at the strobe edge, upper wdata bits dropped
  always_ff @(posedge sys.bus or negedge sys.arst_n) begin
    if (!sys.arst_n) begin
      adc_mul <= {2{GAIN_UNITY}};
      adc_sum <= '0;
      dac_mul <= {2{GAIN_UNITY}};
      dac_sum <= '0;
    end else if (sys.wen) begin
      if (sel[0]) adc_mul[0] <= sys.wdata[DWM-1:0];
      if (sel[1]) adc_sum[0] <= sys.wdata[DWS-1:0];
      if (sel[2]) adc_mul[1] <= sys.wdata[DWM-1:0];
      if (sel[3]) adc_sum[1] <= sys.wdata[DWS-1:0];
      if (sel[4]) dac_mul[0] <= sys.wdata[DWM-1:0];
      if (sel[5]) dac_sum[0] <= sys.wdata[DWS-1:0];
      if (sel[6]) dac_mul[1] <= sys.wdata[DWM-1:0];
      if (sel[7]) dac_sum[1] <= sys.wdata[DWS-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus response
  ////////////////////////////////////////////////////////////

  // Ack one cycle after any strobe, err on a miss
  always_ff @(posedge sys.bus or negedge sys.arst_n) begin
    if (!sys.arst_n) begin
      sys.ack <= 1'b0;
      sys.err <= 1'b0;
    end else begin
      sys.ack <= sys.wen | sys.ren;
      sys.err <= (sys.wen | sys.ren) & ~hit;
    end
  end

  // Read data captured with the strobe
  // Zero on a miss, as the mux default
  always_ff @(posedge sys.bus) begin
    if (sys.wen | sys.ren) begin
      sys.rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* hw/calib_channel.sv */
/*
 * Calibration pipeline for one sample stream
 * out = saturate((in * gain) >>> (DWM-2) + offset), two cycles of latency
 */

`timescale 1ns/100ps
`default_nettype none

module calib_channel #(
  parameter int unsigned DWM = calib_pkg::CALIB_DWM_DEF,
  parameter int unsigned DWS = calib_pkg::CALIB_DWS_DEF
) (
  input  logic                  bus,
  input  logic                  arst_n,
  // Settings from the register block
  input  logic signed [DWM-1:0] gain,
  input  logic signed [DWS-1:0] offset,
  // Sample in
  input  logic                  in_valid,
  input  logic signed [DWS-1:0] in_data,
  // Sample out
  output logic                  out_valid,
  output logic signed [DWS-1:0] out_data
);

  // Full product width
  localparam int unsigned PW = DWS + DWM;
  // Product width after the unity shift
  localparam int unsigned SW = PW - (DWM - 2);

  // Output limits
  localparam logic signed [DWS-1:0] SAT_MAX = {1'b0, {(DWS-1){1'b1}}};
  localparam logic signed [DWS-1:0] SAT_MIN = {1'b1, {(DWS-1){1'b0}}};

  ////////////////////////////////////////////////////////////
  // Stage one
  ////////////////////////////////////////////////////////////

  logic                  vld_s1;
  logic signed [PW-1:0]  prod_s1;
  logic signed [DWS-1:0] offs_s1;

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      vld_s1 <= 1'b0;
    end else begin
      vld_s1 <= in_valid;
    end
  end

  // Gain and offset as seen on entry
  always_ff @(posedge bus) begin
    if (in_valid) begin
      prod_s1 <= in_data * gain;
      offs_s1 <= offset;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage two
  ////////////////////////////////////////////////////////////

  logic signed [SW-1:0]  prod_sh;
  // One guard bit for the offset add
  logic signed [SW:0]    sum;
  logic signed [DWS-1:0] sat;

  assign prod_sh = SW'(prod_s1 >>> (DWM - 2));
  assign sum     = prod_sh + offs_s1;

  // Clamp to the DWS range
  always_comb begin
    if (sum > SAT_MAX) begin
      sat = SAT_MAX;
    end else if (sum < SAT_MIN) begin
      sat = SAT_MIN;
    end else begin
      sat = sum[DWS-1:0];
    end
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= vld_s1;
    end
  end

  always_ff @(posedge bus) begin
    if (vld_s1) begin
      out_data <= sat;
    end
  end

endmodule

`default_nettype wire

/* hw/calib_top.sv */
/*
 * Calibration subsystem top level
 * Register block on the system bus feeding two ADC and two DAC pipelines
 */

`timescale 1ns/100ps
`default_nettype none

module calib_top #(
  parameter int unsigned DWM = calib_pkg::CALIB_DWM_DEF,
  parameter int unsigned DWS = calib_pkg::CALIB_DWS_DEF
) (
  input  logic                        bus,
  input  logic                        arst_n,
  // System bus
  input  calib_pkg::bus_addr_t        addr,
  input  calib_pkg::bus_data_t        wdata,
  input  logic                        wen,
  input  logic                        ren,
  output calib_pkg::bus_data_t        rdata,
  output logic                        ack,
  output logic                        err,
  // ADC streams
  input  logic [1:0]                  adc_in_valid,
  input  logic signed [1:0][DWS-1:0]  adc_in_data,
  output logic [1:0]                  adc_out_valid,
  output logic signed [1:0][DWS-1:0]  adc_out_data,
  // DAC streams
  input  logic [1:0]                  dac_in_valid,
  input  logic signed [1:0][DWS-1:0]  dac_in_data,
  output logic [1:0]                  dac_out_valid,
  output logic signed [1:0][DWS-1:0]  dac_out_data
);

  ////////////////////////////////////////////////////////////
  // System bus
  ////////////////////////////////////////////////////////////

  sys_bus_if sys_bus (
    .bus    (bus),
    .arst_n (arst_n)
  );

  // Master side from the top ports
  assign sys_bus.addr  = addr;
  assign sys_bus.wdata = wdata;
  assign sys_bus.wen   = wen;
  assign sys_bus.ren   = ren;
  assign rdata         = sys_bus.rdata;
  assign ack           = sys_bus.ack;
  assign err           = sys_bus.err;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  logic signed [1:0][DWM-1:0] adc_mul;
  logic signed [1:0][DWS-1:0] adc_sum;
  logic signed [1:0][DWM-1:0] dac_mul;
  logic signed [1:0][DWS-1:0] dac_sum;

  calib_regs #(
    .DWM (DWM),
    .DWS (DWS)
  ) u_regs (
    .sys     (sys_bus.s),
    .adc_mul (adc_mul),
    .adc_sum (adc_sum),
    .dac_mul (dac_mul),
    .dac_sum (dac_sum)
  );

  ////////////////////////////////////////////////////////////
  // Channel pipelines
  ////////////////////////////////////////////////////////////

  // Index 0..1 ADC, 2..3 DAC
  logic [3:0]           ch_in_valid;
  logic [3:0][DWS-1:0]  ch_in_data;
  logic [3:0][DWM-1:0]  ch_gain;
  logic [3:0][DWS-1:0]  ch_offset;
  logic [3:0]           ch_out_valid;
  logic [3:0][DWS-1:0]  ch_out_data;

  assign ch_in_valid = {dac_in_valid, adc_in_valid};
  assign ch_in_data  = {dac_in_data, adc_in_data};
  assign ch_gain     = {dac_mul, adc_mul};
  assign ch_offset   = {dac_sum, adc_sum};

  assign {dac_out_valid, adc_out_valid} = ch_out_valid;
  assign {dac_out_data, adc_out_data}   = ch_out_data;

  for (genvar i = 0; i < 4; i++) begin : g_ch
    calib_channel #(
      .DWM (DWM),
      .DWS (DWS)
    ) u_channel (
      .bus       (bus),
      .arst_n    (arst_n),
      .gain      (ch_gain[i]),
      .offset    (ch_offset[i]),
      .in_valid  (ch_in_valid[i]),
      .in_data   (ch_in_data[i]),
      .out_valid (ch_out_valid[i]),
      .out_data  (ch_out_data[i])
    );
  end

endmodule

`default_nettype wire

/* testbench/tb_calib_checks.svh */
/*
 * Compare tasks for the calibration testbench
 * One task per result kind
 */

`ifndef TB_CALIB_CHECKS_SVH
`define TB_CALIB_CHECKS_SVH

// Bus read data
task automatic check_rdata(input bus_data_t got, input bus_data_t exp);
  if (got !== exp) begin
    fail_run($sformatf("[ERROR] rdata: got 0x%h, expected 0x%h", got, exp));
  end
endtask

// Bus error flag
task automatic check_err(input logic got, input logic exp);
  if (got !== exp) begin
    fail_run($sformatf("[ERROR] err: got 0x%h, expected 0x%h", got, exp));
  end
endtask

// Calibrated sample of one stream
// Streams 0 and 1 are ADC, 2 and 3 are DAC
task automatic check_sample(input int s, input sample_t got, input sample_t exp);
  string name;
  name = $sformatf("%s_out_data[%0d]", (s < 2) ? "adc" : "dac", s % 2);
  if (got !== exp) begin
    fail_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
  end
endtask

`endif

/* testbench/tb_calib.sv */
/*
 * Testbench for the calibration subsystem
 * Replays a trace of bus operations and samples against calib_top
 */

`timescale 1ns/100ps
`default_nettype none

module tb_calib;
  import calib_pkg::*;

  localparam int unsigned DWS        = CALIB_DWS_DEF;
  localparam int          CLK_PERIOD = 20;
  localparam int          DRV_DLY    = 2;
  localparam int          RST_CYCLES = 16;
  localparam int          SEED       = 2757;

  typedef logic signed [DWS-1:0] sample_t;

  logic                       bus;
  logic                       arst_n;
  bus_addr_t                  addr;
  bus_data_t                  wdata;
  logic                       wen;
  logic                       ren;
  bus_data_t                  rdata;
  logic                       ack;
  logic                       err;
  logic [1:0]                 adc_in_valid;
  logic signed [1:0][DWS-1:0] adc_in_data;
  logic [1:0]                 adc_out_valid;
  logic signed [1:0][DWS-1:0] adc_out_data;
  logic [1:0]                 dac_in_valid;
  logic signed [1:0][DWS-1:0] dac_in_data;
  logic [1:0]                 dac_out_valid;
  logic signed [1:0][DWS-1:0] dac_out_data;

  // Trace columns
  byte       kind_q[$];
  bus_data_t f1_q[$];
  bus_data_t f2_q[$];
  bus_data_t f3_q[$];
  logic      trace_loaded = 1'b0;

  // Expected output per stream in a two-deep pipe model
  sample_t    exp_in [4];
  sample_t    pipe_d0 [4];
  sample_t    pipe_d1 [4];
  logic [3:0] pipe_v0;
  logic [3:0] pipe_v1;

  calib_top #(
    .DWM (CALIB_DWM_DEF),
    .DWS (CALIB_DWS_DEF)
  ) DUT (
    .bus           (bus),
    .arst_n        (arst_n),
    .addr          (addr),
    .wdata         (wdata),
    .wen           (wen),
    .ren           (ren),
    .rdata         (rdata),
    .ack           (ack),
    .err           (err),
    .adc_in_valid  (adc_in_valid),
    .adc_in_data   (adc_in_data),
    .adc_out_valid (adc_out_valid),
    .adc_out_data  (adc_out_data),
    .dac_in_valid  (dac_in_valid),
    .dac_in_data   (dac_in_data),
    .dac_out_valid (dac_out_valid),
    .dac_out_data  (dac_out_data)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  `include "tb_calib_checks.svh"

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic idle_inputs();
    addr         = '0;
    wdata        = '0;
    wen          = 1'b0;
    ren          = 1'b0;
    adc_in_valid = '0;
    dac_in_valid = '0;
  endtask

  // Comment lines start with #
  task automatic load_trace();
    int        fd;
    int        n;
    string     line;
    byte       kc;
    bus_data_t a1;
    bus_data_t a2;
    bus_data_t a3;
    fd = $fopen("testbench/calib_trace.txt", "r");
    if (fd == 0) fail_run("Could not open the trace file");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%c %h %h %h", kc, a1, a2, a3);
      if (n != 4 || !(kc == "W" || kc == "R" || kc == "S")) begin
        fail_run({"Malformed trace line: ", line});
      end
      kind_q.push_back(kc);
      f1_q.push_back(a1);
      f2_q.push_back(a2);
      f3_q.push_back(a3);
    end
    $fclose(fd);
    if (kind_q.size() == 0) fail_run("The trace holds no operations");
    trace_loaded = 1'b1;
  endtask

  // One strobe cycle with ack only in the following cycle
  task automatic run_bus(input byte kind, input bus_addr_t a, input bus_data_t d,
                         input logic exp_err);
    @(posedge bus);
    #DRV_DLY;
    idle_inputs();
    addr = a;
    if (kind == "W") begin
      wen   = 1'b1;
      wdata = d;
    end else begin
      ren = 1'b1;
    end
    @(negedge bus);
    if (ack !== 1'b0) fail_run("Bus ack came in the same cycle as the strobe");
    @(posedge bus);
    #DRV_DLY;
    idle_inputs();
    @(negedge bus);
    if (ack !== 1'b1) fail_run("Bus ack missing one cycle after the strobe");
    check_err(err, exp_err);
    if (kind == "R") begin
      check_rdata(rdata, d);
    end else if (exp_err) begin
      // Unmapped write answers with zero data
      check_rdata(rdata, '0);
    end
  endtask

  task automatic drive_sample(input int s, input sample_t din, input sample_t dexp);
    @(posedge bus);
    #DRV_DLY;
    idle_inputs();
    exp_in[s[1:0]] = dexp;
    if (s < 2) begin
      adc_in_valid[s[0]] = 1'b1;
      adc_in_data[s[0]]  = din;
    end else begin
      dac_in_valid[s[0]] = 1'b1;
      dac_in_data[s[0]]  = din;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////

  function automatic sample_t out_sample(input int s);
    if (s < 2) return adc_out_data[s[0]];
    return dac_out_data[s[0]];
  endfunction

  // Sampled mid-cycle with out_valid due two cycles after in_valid
  always @(negedge bus) begin : sample_monitor
    logic [3:0] in_v;
    logic [3:0] out_v;
    in_v  = {dac_in_valid, adc_in_valid};
    out_v = {dac_out_valid, adc_out_valid};
    if (!arst_n) begin
      pipe_v0 = '0;
      pipe_v1 = '0;
    end else begin
      for (int s = 0; s < 4; s++) begin
        if (pipe_v1[s[1:0]] && out_v[s[1:0]] !== 1'b1) begin
          fail_run($sformatf("Stream %0d gave no out_valid two cycles after in_valid", s));
        end
        if (!pipe_v1[s[1:0]] && out_v[s[1:0]] !== 1'b0) begin
          fail_run($sformatf("Stream %0d raised out_valid with no sample in flight", s));
        end
        if (pipe_v1[s[1:0]]) check_sample(s, out_sample(s), pipe_d1[s[1:0]]);
      end
      pipe_v1 = pipe_v0;
      pipe_d1 = pipe_d0;
      pipe_v0 = in_v;
      pipe_d0 = exp_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // Clock, watchdog and trace replay
  ////////////////////////////////////////////////////////////

  initial begin
    bus = 1'b0;
    forever #(CLK_PERIOD / 2) bus = ~bus;
  end

  // 40 cycles per trace line
  initial begin : watchdog
    longint limit_ns;
    wait (trace_loaded);
    limit_ns = longint'(kind_q.size()) * 40 * CLK_PERIOD;
    #(limit_ns);
    fail_run("Timeout: the trace did not finish in time");
  end

  initial begin : replay
    int gap;
    void'($urandom(SEED));
    arst_n      = 1'b0;
    adc_in_data = '0;
    dac_in_data = '0;
    idle_inputs();
    load_trace();
    repeat (RST_CYCLES) @(posedge bus);
    #DRV_DLY;
    arst_n = 1'b1;
    foreach (kind_q[i]) begin
      if (kind_q[i] == "S") begin
        // Samples run back to back
        drive_sample(int'(f1_q[i][1:0]), f2_q[i][DWS-1:0], f3_q[i][DWS-1:0]);
      end else begin
        gap = int'($urandom % 3);
        repeat (gap) begin
          @(posedge bus);
          #DRV_DLY;
          idle_inputs();
        end
        run_bus(kind_q[i], f1_q[i], f2_q[i], f3_q[i][0]);
      end
    end
    @(posedge bus);
    #DRV_DLY;
    idle_inputs();
    // Drain the pipelines
    repeat (4) @(posedge bus);
    @(negedge bus);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+testbench
hw/calib_pkg.sv
hw/sys_bus_if.sv
hw/calib_regs.sv
hw/calib_channel.sv
hw/calib_top.sv
testbench/tb_calib.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_calib
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/calib_trace.txt */
# W addr data exp_err | R addr exp_rdata exp_err | S stream in exp_out (all hex)
# Streams 0..1 are ADC 0..1, 2..3 are DAC 0..1, samples are 14-bit
# Reset values
R 00000040 00004000 0
R 00000044 00000000 0
R 00000048 00004000 0
R 0000004C 00000000 0
R 00000050 00004000 0
R 00000054 00000000 0
R 00000058 00004000 0
R 0000005C 00000000 0
S 0 0123 0123
S 0 3FFB 3FFB
S 1 1FFF 1FFF
S 2 0AAA 0AAA
S 3 2000 2000
# Settings with truncated upper bits, then unmapped accesses
W 00000040 00002000 0
W 00000044 00000064 0
W 00000048 12348000 0
W 0000004C FFFF3FCE 0
W 00000050 00006000 0
W 00000054 0001FF38 0
W 00000058 0000C000 0
W 0000005C 000003E8 0
W 00000060 00001234 1
R 0000003C 00000000 1
R 00000040 00002000 0
R 00000044 00000064 0
R 00000048 FFFF8000 0
R 0000004C FFFFFFCE 0
R 00000050 00006000 0
R 00000054 FFFFFF38 0
R 00000058 FFFFC000 0
R 0000005C 000003E8 0
# Gain and offset applied
S 0 03E8 0258
S 0 3FF9 0060
S 1 012C 3D76
S 2 07D0 0AF0
S 3 1000 33E8
S 3 2000 1FFF
# Saturation
S 2 20C0 2000
S 1 2C78 1FFF
W 00000044 00001F40 0
S 0 03E8 1FFF
W 0000005C 00002000 0
S 3 0064 2000
R 0000005C FFFFE000 0
